// ==== src/regRenamePkg.sv ====
// shared widths, physical tag layout and reset values of the rename register file
// every RTL module of the rename subsystem imports what it needs from here
package regRenamePkg;

	localparam int ARCH_REGS = 32;
	localparam int ARCH_BITS = 5;

	// copy index sized for the deepest supported configuration
	localparam int MAX_DEPTH = 8;
	localparam int COPY_BITS = 3;

	localparam int XLEN = 64;

	// architectural index plus copy index
	typedef struct packed {
		logic [ARCH_BITS-1:0] arch;
		logic [COPY_BITS-1:0] copy;
	} physTag_t;

	// after reset only copy 0 is in use, active, architectural and written back
	localparam logic [MAX_DEPTH-1:0] RESET_COPY_MASK = MAX_DEPTH'(1);
	localparam logic [COPY_BITS-1:0] RESET_PTR = '0;
	localparam logic [XLEN-1:0] RESET_DATA = '0;

endpackage

// ==== src/renameAlloc.sv ====
`timescale 1ns/1ns
// rename allocator: maps a destination register onto its lowest free physical copy
// and keeps the speculative active pointer of every architectural register
module renameAlloc
	import regRenamePkg::*;
#(
	parameter int RNDEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic renameValid,
	input  logic [ARCH_BITS-1:0] renameRd,
	output logic renameReady,
	output physTag_t renameTag,

	input  logic [ARCH_REGS-1:0][RNDEPTH-1:0] copyUsed,
	output logic allocValid,
	output logic [ARCH_REGS-1:0][$clog2(RNDEPTH)-1:0] activePtr
);

	localparam int RNBIT = $clog2(RNDEPTH);

	logic [RNDEPTH-1:0] rdUsed;
	logic [RNBIT-1:0] freeIdx;
	logic hasFree;
	logic isX0;
	logic accept;

	// active pointers of x1..x31, x0 stays on copy 0
	logic [RNBIT-1:0] ptrQ [1:ARCH_REGS-1];

	assign rdUsed = copyUsed[renameRd];
	assign isX0 = (renameRd == '0);

	// priority encoder, lowest unused copy wins
	always_comb begin
		freeIdx = '0;
		hasFree = 1'b0;
		for (int c = RNDEPTH - 1; c >= 0; c--) begin
			if (!rdUsed[c]) begin
				freeIdx = RNBIT'(c);
				hasFree = 1'b1;
			end
		end
	end

	// stall only when every copy of the register is taken
	// x0 is always accepted and never takes a copy
	assign renameReady = isX0 | hasFree;
	assign accept = renameValid & renameReady;
	assign allocValid = accept & ~isX0;

	always_comb begin
		renameTag.arch = renameRd;
		renameTag.copy = isX0 ? RESET_PTR : COPY_BITS'(freeIdx);
	end

	// move the active pointer of the renamed register to its new copy
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int r = 1; r < ARCH_REGS; r++) begin
				ptrQ[r] <= RNBIT'(RESET_PTR);
			end
		end else if (allocValid) begin
			for (int r = 1; r < ARCH_REGS; r++) begin
				if (renameRd == ARCH_BITS'(r)) begin
					ptrQ[r] <= freeIdx;
				end
			end
		end
	end

	always_comb begin
		activePtr[0] = RNBIT'(RESET_PTR);
		for (int r = 1; r < ARCH_REGS; r++) begin
			activePtr[r] = ptrQ[r];
		end
	end

endmodule

// ==== src/phyRegister.sv ====
`timescale 1ns/1ns
// physical register state: copy data, in-use bits, writeback log and architectural pointers
// allocation, writeback and commit arrive as single-cycle valid strobes
module phyRegister
	import regRenamePkg::*;
#(
	parameter int RNDEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic allocValid,
	input  physTag_t allocTag,

	input  logic wbValid,
	input  physTag_t wbTag,
	input  logic [XLEN-1:0] wbData,

	input  logic commitValid,
	input  physTag_t commitTag,

	output logic [ARCH_REGS-1:0][RNDEPTH-1:0] copyUsed,
	output logic [ARCH_REGS-1:0][RNDEPTH-1:0][XLEN-1:0] copyData,
	output logic [ARCH_REGS-1:0][RNDEPTH-1:0] wbDone
);

	localparam int RNBIT = $clog2(RNDEPTH);
	localparam logic [RNDEPTH-1:0] COPY0 = RESET_COPY_MASK[RNDEPTH-1:0];

	logic [RNBIT-1:0] allocCopy;
	logic [RNBIT-1:0] wbCopy;
	logic [RNBIT-1:0] commitCopy;

	// state of x1..x31, x0 is constant
	logic [RNDEPTH-1:0] usedQ [1:ARCH_REGS-1];
	logic [RNDEPTH-1:0] wbLog [1:ARCH_REGS-1];
	logic [RNBIT-1:0] archPtr [1:ARCH_REGS-1];
	logic [RNDEPTH-1:0][XLEN-1:0] dataQ [1:ARCH_REGS-1];

	assign allocCopy = allocTag.copy[RNBIT-1:0];
	assign wbCopy = wbTag.copy[RNBIT-1:0];
	assign commitCopy = commitTag.copy[RNBIT-1:0];

	// rename sets a used bit, writeback sets a log bit, commit clears both
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int r = 1; r < ARCH_REGS; r++) begin
				usedQ[r] <= COPY0;
				wbLog[r] <= COPY0;
				archPtr[r] <= RNBIT'(RESET_PTR);
			end
		end else begin
			for (int r = 1; r < ARCH_REGS; r++) begin
				if (allocValid && allocTag.arch == ARCH_BITS'(r)) begin
					usedQ[r][allocCopy] <= 1'b1;
				end
				if (wbValid && wbTag.arch == ARCH_BITS'(r)) begin
					wbLog[r][wbCopy] <= 1'b1;
				end
				// old architectural copy is released
				if (commitValid && commitTag.arch == ARCH_BITS'(r)
						&& commitCopy != archPtr[r]) begin
					archPtr[r] <= commitCopy;
					usedQ[r][archPtr[r]] <= 1'b0;
					wbLog[r][archPtr[r]] <= 1'b0;
				end
			end
		end
	end

	// data array, every copy reads zero after reset
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int r = 1; r < ARCH_REGS; r++) begin
				dataQ[r] <= {RNDEPTH{RESET_DATA}};
			end
		end else if (wbValid) begin
			for (int r = 1; r < ARCH_REGS; r++) begin
				if (wbTag.arch == ARCH_BITS'(r)) begin
					dataQ[r][wbCopy] <= wbData;
				end
			end
		end
	end

	// x0 holds copy 0 only, zero and written back
	always_comb begin
		copyUsed[0] = COPY0;
		wbDone[0] = COPY0;
		copyData[0] = {RNDEPTH{RESET_DATA}};
		for (int r = 1; r < ARCH_REGS; r++) begin
			copyUsed[r] = usedQ[r];
			wbDone[r] = wbLog[r];
			copyData[r] = dataQ[r];
		end
	end

endmodule

// ==== src/operandRead.sv ====
`timescale 1ns/1ns
// operand read stage: two sources looked up through the active pointers
// data and ready flags come out one cycle after readEn
module operandRead
	import regRenamePkg::*;
#(
	parameter int RNDEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic readEn,
	input  logic [ARCH_BITS-1:0] readRs1,
	input  logic [ARCH_BITS-1:0] readRs2,

	input  logic [ARCH_REGS-1:0][$clog2(RNDEPTH)-1:0] activePtr,
	input  logic [ARCH_REGS-1:0][RNDEPTH-1:0][XLEN-1:0] copyData,
	input  logic [ARCH_REGS-1:0][RNDEPTH-1:0] wbDone,

	output logic [XLEN-1:0] rs1Data,
	output logic rs1Ready,
	output logic [XLEN-1:0] rs2Data,
	output logic rs2Ready,
	output logic readValid
);

	localparam int RNBIT = $clog2(RNDEPTH);

	logic [RNBIT-1:0] rs1Copy;
	logic [RNBIT-1:0] rs2Copy;
	logic [XLEN-1:0] rs1Sel;
	logic [XLEN-1:0] rs2Sel;
	logic rs1Done;
	logic rs2Done;

	// the active copy is the youngest rename of each source
	assign rs1Copy = activePtr[readRs1];
	assign rs2Copy = activePtr[readRs2];

	// x0 reads zero and is always ready
	assign rs1Sel = (readRs1 == '0) ? RESET_DATA : copyData[readRs1][rs1Copy];
	assign rs2Sel = (readRs2 == '0) ? RESET_DATA : copyData[readRs2][rs2Copy];
	assign rs1Done = (readRs1 == '0) | wbDone[readRs1][rs1Copy];
	assign rs2Done = (readRs2 == '0) | wbDone[readRs2][rs2Copy];

	always_ff @(posedge CLK) begin
		if (rst) begin
			readValid <= 1'b0;
		end else begin
			readValid <= readEn;
		end
	end

	always_ff @(posedge CLK) begin
		if (readEn) begin
			rs1Data <= rs1Sel;
			rs1Ready <= rs1Done;
			rs2Data <= rs2Sel;
			rs2Ready <= rs2Done;
		end
	end

endmodule

// ==== src/renameRegFile.sv ====
`timescale 1ns/1ns
// top level of the rename subsystem: allocator, physical register state and read stage
// RNDEPTH sets the number of physical copies per architectural register
module renameRegFile
	import regRenamePkg::*;
#(
	parameter int RNDEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic renameValid,
	input  logic [ARCH_BITS-1:0] renameRd,
	output logic renameReady,
	output physTag_t renameTag,

	input  logic wbValid,
	input  physTag_t wbTag,
	input  logic [XLEN-1:0] wbData,

	input  logic commitValid,
	input  physTag_t commitTag,

	input  logic readEn,
	input  logic [ARCH_BITS-1:0] readRs1,
	input  logic [ARCH_BITS-1:0] readRs2,
	output logic [XLEN-1:0] rs1Data,
	output logic rs1Ready,
	output logic [XLEN-1:0] rs2Data,
	output logic rs2Ready,
	output logic readValid
);

	logic allocValid;
	logic [ARCH_REGS-1:0][RNDEPTH-1:0] copyUsed;
	logic [ARCH_REGS-1:0][$clog2(RNDEPTH)-1:0] activePtr;
	logic [ARCH_REGS-1:0][RNDEPTH-1:0][XLEN-1:0] copyData;
	logic [ARCH_REGS-1:0][RNDEPTH-1:0] wbDone;

	renameAlloc #(.RNDEPTH(RNDEPTH)) allocInst (
		.CLK(CLK),
		.rst(rst),
		.renameValid(renameValid),
		.renameRd(renameRd),
		.renameReady(renameReady),
		.renameTag(renameTag),
		.copyUsed(copyUsed),
		.allocValid(allocValid),
		.activePtr(activePtr)
	);

	// allocation reuses the accepted rename tag
	phyRegister #(.RNDEPTH(RNDEPTH)) phyInst (
		.CLK(CLK),
		.rst(rst),
		.allocValid(allocValid),
		.allocTag(renameTag),
		.wbValid(wbValid),
		.wbTag(wbTag),
		.wbData(wbData),
		.commitValid(commitValid),
		.commitTag(commitTag),
		.copyUsed(copyUsed),
		.copyData(copyData),
		.wbDone(wbDone)
	);

	operandRead #(.RNDEPTH(RNDEPTH)) readInst (
		.CLK(CLK),
		.rst(rst),
		.readEn(readEn),
		.readRs1(readRs1),
		.readRs2(readRs2),
		.activePtr(activePtr),
		.copyData(copyData),
		.wbDone(wbDone),
		.rs1Data(rs1Data),
		.rs1Ready(rs1Ready),
		.rs2Data(rs2Data),
		.rs2Ready(rs2Ready),
		.readValid(readValid)
	);

endmodule

// ==== bench/renameRegFile_assertions.sv ====
`timescale 1ns/1ns
// concurrent checks on the physical register state, bound into phyRegister
module renameRegFile_assertions
	import regRenamePkg::*;
#(
	parameter int RNDEPTH = 4
) (
	input  logic CLK,
	input  logic rst,
	input  logic allocValid,
	input  physTag_t allocTag,
	input  logic commitValid,
	input  physTag_t commitTag,
	input  logic [ARCH_REGS-1:0][RNDEPTH-1:0] copyUsed,
	input  logic [ARCH_REGS-1:0][RNDEPTH-1:0] wbDone,
	input  logic [ARCH_REGS-1:0][RNDEPTH-1:0][XLEN-1:0] copyData
);

	localparam int RNBIT = $clog2(RNDEPTH);

	// allocation only ever takes a free copy
	allocFree: assert property (@(posedge CLK) disable iff (rst)
		allocValid |-> !copyUsed[allocTag.arch][allocTag.copy[RNBIT-1:0]])
		else $error("copy allocated while its used bit is set");

	commitWritten: assert property (@(posedge CLK) disable iff (rst)
		commitValid |-> wbDone[commitTag.arch][commitTag.copy[RNBIT-1:0]])
		else $error("commit names a copy that was not written back");

	// x0 never takes a physical copy, so its entries stay as after reset
	x0NoAlloc: assert property (@(posedge CLK) disable iff (rst)
		allocValid |-> allocTag.arch != '0)
		else $error("copy of x0 allocated by a rename");

endmodule

// ==== bench/renameChecker.sv ====
`timescale 1ns/1ns
// compares rename and read responses of the DUT with the expected values from the data file
// renames are checked in their own cycle, reads when readValid follows readEn
module renameChecker
	import regRenamePkg::*;
(
	input  logic CLK,
	input  logic rst,
	input  physTag_t renameTag,
	input  logic renameReady,
	input  logic readValid,
	input  logic [XLEN-1:0] rs1Data,
	input  logic rs1Ready,
	input  logic [XLEN-1:0] rs2Data,
	input  logic rs2Ready,
	input  logic expRename,
	input  physTag_t expTag,
	input  logic expReady,
	input  logic expRead,
	input  logic [XLEN-1:0] expRs1Data,
	input  logic expRs1Ready,
	input  logic [XLEN-1:0] expRs2Data,
	input  logic expRs2Ready,
	output int errorCount,
	output int checkCount
);

	logic readPending;
	logic [XLEN-1:0] wantRs1Data;
	logic wantRs1Ready;
	logic [XLEN-1:0] wantRs2Data;
	logic wantRs2Ready;

	initial begin
		errorCount = 0;
		checkCount = 0;
		readPending = 1'b0;
	end

	task automatic compareValue(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	always @(posedge CLK) begin
		if (rst) begin
			readPending = 1'b0;
		end else begin
			if (expRename) begin
				compareValue("renameReady", XLEN'(renameReady), XLEN'(expReady));
				// tag carries no meaning while the rename stalls
				if (expReady) begin
					compareValue("renameTag", XLEN'(renameTag), XLEN'(expTag));
				end
			end
			if (readPending) begin
				if (!readValid) begin
					errorCount++;
					$display("Error at %0t ns: readValid did not rise one cycle after readEn",
						$time);
				end else begin
					compareValue("rs1Data", rs1Data, wantRs1Data);
					compareValue("rs1Ready", XLEN'(rs1Ready), XLEN'(wantRs1Ready));
					compareValue("rs2Data", rs2Data, wantRs2Data);
					compareValue("rs2Ready", XLEN'(rs2Ready), XLEN'(wantRs2Ready));
				end
			end else if (readValid) begin
				errorCount++;
				$display("Error at %0t ns: readValid rose without a read in the cycle before",
					$time);
			end
			// hold the read expectation until the result shows up
			readPending = expRead;
			if (expRead) begin
				wantRs1Data = expRs1Data;
				wantRs1Ready = expRs1Ready;
				wantRs2Data = expRs2Data;
				wantRs2Ready = expRs2Ready;
			end
		end
	end

endmodule

// ==== bench/renameRegFile_tb.sv ====
`timescale 1ns/1ns
// testbench of the rename register file, replays bench/rename_input.txt on falling edges
// renameChecker compares the responses; run from the project root
module renameRegFile_tb
	import regRenamePkg::*;
();

	localparam int RNDEPTH = 4;
	localparam int WORDS = 8;
	localparam int MAX_OPS = 64;

	logic CLK;
	logic rst;
	logic renameValid;
	logic [ARCH_BITS-1:0] renameRd;
	logic renameReady;
	physTag_t renameTag;
	logic wbValid;
	physTag_t wbTag;
	logic [XLEN-1:0] wbData;
	logic commitValid;
	physTag_t commitTag;
	logic readEn;
	logic [ARCH_BITS-1:0] readRs1;
	logic [ARCH_BITS-1:0] readRs2;
	logic [XLEN-1:0] rs1Data;
	logic rs1Ready;
	logic [XLEN-1:0] rs2Data;
	logic rs2Ready;
	logic readValid;

	// expected values, each group with its marker
	logic expRename;
	physTag_t expTag;
	logic expReady;
	logic expRead;
	logic [XLEN-1:0] expRs1Data;
	logic expRs1Ready;
	logic [XLEN-1:0] expRs2Data;
	logic expRs2Ready;
	int errorCount;
	int checkCount;

	// one operation is WORDS words: opcode, three operands, four expected values
	logic [63:0] opMem [0:MAX_OPS*WORDS-1];
	int nOps;
	int loadErrors;
	int cycles;
	int maxCycles;

	renameRegFile #(.RNDEPTH(RNDEPTH)) uut (.*);
	renameChecker compareInst (.*);
	bind phyRegister renameRegFile_assertions #(.RNDEPTH(RNDEPTH)) phyChecks (.*);

	always #5 CLK = ~CLK;

	task automatic clearStrobes();
		renameValid = 1'b0;
		wbValid = 1'b0;
		commitValid = 1'b0;
		readEn = 1'b0;
		expRename = 1'b0;
		expRead = 1'b0;
	endtask

	task automatic applyOp(input int idx);
		int base;
		base = idx * WORDS;
		clearStrobes();
		case (opMem[base][3:0])
			4'h1: begin
				renameValid = 1'b1;
				renameRd = opMem[base+1][ARCH_BITS-1:0];
				expRename = 1'b1;
				expTag.arch = opMem[base+1][ARCH_BITS-1:0];
				expTag.copy = opMem[base+4][COPY_BITS-1:0];
				expReady = opMem[base+5][0];
			end
			4'h2: begin
				wbValid = 1'b1;
				wbTag.arch = opMem[base+1][ARCH_BITS-1:0];
				wbTag.copy = opMem[base+2][COPY_BITS-1:0];
				wbData = opMem[base+3];
			end
			4'h3: begin
				commitValid = 1'b1;
				commitTag.arch = opMem[base+1][ARCH_BITS-1:0];
				commitTag.copy = opMem[base+2][COPY_BITS-1:0];
			end
			4'h4: begin
				readEn = 1'b1;
				readRs1 = opMem[base+1][ARCH_BITS-1:0];
				readRs2 = opMem[base+2][ARCH_BITS-1:0];
				expRead = 1'b1;
				expRs1Data = opMem[base+4];
				expRs1Ready = opMem[base+5][0];
				expRs2Data = opMem[base+6];
				expRs2Ready = opMem[base+7][0];
			end
			default: begin
				// idle cycle
			end
		endcase
	endtask

	// run limit grows with the number of operations
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles > maxCycles) begin
			$display("Timeout after %0d cycles, the operation sequence did not complete", maxCycles);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount + loadErrors + 1);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		CLK = 1'b0;
		rst = 1'b1;
		clearStrobes();
		renameRd = '0;
		wbTag = '0;
		wbData = '0;
		commitTag = '0;
		readRs1 = '0;
		readRs2 = '0;
		expTag = '0;
		expReady = 1'b0;
		expRs1Data = '0;
		expRs1Ready = 1'b0;
		expRs2Data = '0;
		expRs2Ready = 1'b0;
		cycles = 0;
		nOps = 0;
		loadErrors = 0;
		$readmemh("bench/rename_input.txt", opMem);
		// opcode f ends the list
		while (nOps < MAX_OPS && opMem[nOps*WORDS] !== 64'hf) begin
			nOps++;
		end
		if (nOps == MAX_OPS) begin
			$display("Data file bench/rename_input.txt missing or without end marker");
			loadErrors = 1;
			nOps = 0;
		end
		maxCycles = nOps * 4 + 20;

		repeat (4) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		for (int i = 0; i < nOps; i++) begin
			@(negedge CLK);
			applyOp(i);
		end
		@(negedge CLK);
		clearStrobes();
		// the last read answers one cycle later
		repeat (2) @(negedge CLK);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount + loadErrors);
		if (errorCount + loadErrors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== bench/rename_input.txt ====
// op rd/rs1 rs2/copy data | copy/rs1Data ready/rs1Ready rs2Data rs2Ready (all hex)
// op: 0 idle, 1 rename, 2 writeback, 3 commit, 4 read, f end of list
4 01 02 0 0 1 0 1
2 00 0 55 0 0 0 0
1 00 0 0 0 1 0 0
4 00 00 0 0 1 0 1
1 05 0 0 1 1 0 0
1 05 0 0 2 1 0 0
1 05 0 0 3 1 0 0
1 05 0 0 0 0 0 0
1 05 0 0 0 0 0 0
4 05 01 0 0 0 0 1
2 05 3 1234 0 0 0 0
4 05 00 0 1234 1 0 1
2 05 1 aaaa 0 0 0 0
4 01 05 0 0 1 1234 1
1 07 0 0 1 1 0 0
3 05 1 0 0 0 0 0
1 05 0 0 0 1 0 0
4 05 07 0 0 0 0 0
2 05 0 c0ffee 0 0 0 0
4 05 05 0 c0ffee 1 c0ffee 1
2 07 1 77 0 0 0 0
0 00 00 0 0 0 0 0
4 07 00 0 77 1 0 1
f 00 00 0 0 0 0 0

// ==== compile.f ====
src/regRenamePkg.sv
src/renameAlloc.sv
src/phyRegister.sv
src/operandRead.sv
src/renameRegFile.sv
bench/renameRegFile_assertions.sv
bench/renameChecker.sv
bench/renameRegFile_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rename register file testbench with Verilator, from the project root
rm -f build.log sim.log
verilator --binary --timing --assert -f compile.f --top-module renameRegFile_tb \
	-o renameSim > build.log 2>&1 \
	&& ./obj_dir/renameSim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0
